// ==== csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ==========================================================
// Global sizes of the machine-mode CSR file
// ==========================================================

// Data width of every CSR and counter half
`define CSR_XLEN 32

// Width of the CSR address field in the instruction
`define CSR_ADDR_W 12

// ==========================================================
// Reset and bit positions
// ==========================================================

// Trap vector after reset, the only CSR that does not clear to zero
`define CSR_MTVEC_RESET 32'h0000_0100

// Timer pending flag inside mip (MTIP)
`define CSR_MTIP_BIT 7

`endif

// ==== csr_arch_pkg.sv ====
`default_nettype none

`include "csr_settings.svh"

package csr_arch_pkg;

    // Implemented CSR addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MINSTRETH = 12'hB82,
        // Custom timer pair
        CSR_MTIME     = 12'hBC0,
        CSR_MTIMECMP  = 12'hBC1,
        // User read-only shadows of the machine counters
        CSR_CYCLE     = 12'hC00,
        CSR_INSTRET   = 12'hC02,
        CSR_CYCLEH    = 12'hC80,
        CSR_INSTRETH  = 12'hC82
    } csr_addr_e;

    // CSRRW / CSRRS / CSRRC, funct3 low bits
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b01,
        CSR_OP_RS = 2'b10,
        CSR_OP_RC = 2'b11
    } csr_op_e;

    typedef enum logic [2:0] {
        TRAP_ILLEGAL_INSTR = 3'd0,
        TRAP_BREAKPOINT    = 3'd1,
        TRAP_MISALIGNED    = 3'd2,
        TRAP_ILLEGAL_CSR   = 3'd3,
        TRAP_TIMER         = 3'd4
    } trap_cause_e;

    // mcause encoding, interrupt flag in the top bit
    function automatic logic [`CSR_XLEN-1:0] cause_value(input trap_cause_e cause);
        case (cause)
            TRAP_ILLEGAL_INSTR: return 32'h0000_0002;
            TRAP_BREAKPOINT:    return 32'h0000_0003;
            TRAP_MISALIGNED:    return 32'h0000_0004;
            TRAP_ILLEGAL_CSR:   return 32'h0000_000B;
            TRAP_TIMER:         return 32'h8000_0007;
            default:            return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== csr_if_pkg.sv ====
`default_nettype none

`include "csr_settings.svh"

package csr_if_pkg;

    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // ==========================================================
    // Core side
    // ==========================================================

    // Operand already selected by the core (register or zimm)
    typedef struct packed {
        csr_arch_pkg::csr_op_e   op;
        logic                    we;
        logic [`CSR_ADDR_W-1:0]  addr;
        csr_word_t               wdata;
    } csr_req_t;

    typedef struct packed {
        csr_word_t rdata;
        logic      illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic                      valid;
        csr_arch_pkg::trap_cause_e cause;
        csr_word_t                 pc;
        csr_word_t                 tval;
    } csr_trap_t;

    // Redirect requests towards the fetch stage
    typedef struct packed {
        logic      jump_en;
        csr_word_t jump_target;
        logic      return_en;
        csr_word_t return_target;
    } csr_pc_update_t;

    // ==========================================================
    // Between the access unit and the storage units
    // ==========================================================

    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        csr_word_t              data;
    } csr_wr_t;

    // Current value of every implemented CSR
    typedef struct packed {
        csr_word_t cycle;
        csr_word_t cycleh;
        csr_word_t instret;
        csr_word_t instreth;
        csr_word_t mcycle;
        csr_word_t mcycleh;
        csr_word_t minstret;
        csr_word_t minstreth;
        csr_word_t mtime;
        csr_word_t mstatus;
        csr_word_t mie;
        csr_word_t mtvec;
        csr_word_t mscratch;
        csr_word_t mepc;
        csr_word_t mcause;
        csr_word_t mtval;
        csr_word_t mip;
        csr_word_t mtimecmp;
    } csr_view_t;

endpackage

`default_nettype wire

// ==== csr_access_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_access_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  var csr_if_pkg::csr_req_t  req,
    input  wire                       req_valid,
    output logic                      req_ready,
    output csr_if_pkg::csr_rsp_t      rsp,
    output logic                      rsp_valid,
    input  wire                       rsp_ready,
    output csr_if_pkg::csr_wr_t       wr,
    input  var csr_if_pkg::csr_view_t view
);
    import csr_arch_pkg::*;
    import csr_if_pkg::*;

    logic                 accept;
    logic                 known;
    logic                 read_only;
    logic                 illegal;
    logic [`CSR_XLEN-1:0] old_val;
    logic [`CSR_XLEN-1:0] new_val;
    csr_rsp_t             rsp_d;

    // Single response slot, a new request may enter as the old one leaves
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    // ==========================================================
    // Address decode and read mux
    // ==========================================================
    always_comb begin
        known = 1'b1;
        unique case (req.addr)
            CSR_CYCLE:     old_val = view.cycle;
            CSR_CYCLEH:    old_val = view.cycleh;
            CSR_INSTRET:   old_val = view.instret;
            CSR_INSTRETH:  old_val = view.instreth;
            CSR_MCYCLE:    old_val = view.mcycle;
            CSR_MCYCLEH:   old_val = view.mcycleh;
            CSR_MINSTRET:  old_val = view.minstret;
            CSR_MINSTRETH: old_val = view.minstreth;
            CSR_MTIME:     old_val = view.mtime;
            CSR_MSTATUS:   old_val = view.mstatus;
            CSR_MIE:       old_val = view.mie;
            CSR_MTVEC:     old_val = view.mtvec;
            CSR_MSCRATCH:  old_val = view.mscratch;
            CSR_MEPC:      old_val = view.mepc;
            CSR_MCAUSE:    old_val = view.mcause;
            CSR_MTVAL:     old_val = view.mtval;
            CSR_MIP:       old_val = view.mip;
            CSR_MTIMECMP:  old_val = view.mtimecmp;
            default: begin
                old_val = '0;
                known   = 1'b0;
            end
        endcase
    end

    // Counter shadows and mtime are hardware owned
    assign read_only = req.addr inside {CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET,
                                        CSR_INSTRETH, CSR_MTIME};
    assign illegal   = !known || (req.we && read_only);

    // ==========================================================
    // Write value
    // ==========================================================
    always_comb begin
        unique case (req.op)
            CSR_OP_RW: new_val = req.wdata;
            CSR_OP_RS: new_val = old_val | req.wdata;
            CSR_OP_RC: new_val = old_val & ~req.wdata;
            default:   new_val = old_val;
        endcase
    end

    assign wr.en   = accept && req.we && !illegal;
    assign wr.addr = req.addr;
    assign wr.data = new_val;

    // Illegal accesses read as zero
    assign rsp_d.rdata   = illegal ? '0 : old_val;
    assign rsp_d.illegal = illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= rsp_d;
        end
    end

    // Stalled response must not change or vanish
    rsp_hold_a: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// ==== csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_counters (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     retire,
    input  var csr_if_pkg::csr_wr_t wr,
    output csr_if_pkg::csr_view_t   view_cnt
);
    import csr_arch_pkg::*;

    logic [`CSR_XLEN-1:0] mcycle_q;
    logic [`CSR_XLEN-1:0] mcycleh_q;
    logic [`CSR_XLEN-1:0] minstret_q;
    logic [`CSR_XLEN-1:0] minstreth_q;
    logic [`CSR_XLEN-1:0] mtime_q;
    logic [`CSR_XLEN-1:0] mcycle_d;
    logic [`CSR_XLEN-1:0] mcycleh_d;
    logic [`CSR_XLEN-1:0] minstret_d;
    logic [`CSR_XLEN-1:0] minstreth_d;

    // One 64-bit counter step, a write to a half replaces its increment
    function automatic logic [2*`CSR_XLEN-1:0] count_step(
        input logic [`CSR_XLEN-1:0] lo,
        input logic [`CSR_XLEN-1:0] hi,
        input logic                 inc,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [`CSR_XLEN-1:0] wdata
    );
        logic [`CSR_XLEN:0]   lo_sum;
        logic [`CSR_XLEN-1:0] hi_sum;
        lo_sum = {1'b0, lo} + {{`CSR_XLEN{1'b0}}, inc};
        // Carry out of the low half reaches the high half even on a low write
        hi_sum = hi + {{(`CSR_XLEN-1){1'b0}}, lo_sum[`CSR_XLEN]};
        return {(wr_hi ? wdata : hi_sum), (wr_lo ? wdata : lo_sum[`CSR_XLEN-1:0])};
    endfunction

    always_comb begin
        {mcycleh_d, mcycle_d} = count_step(mcycle_q, mcycleh_q, 1'b1,
            wr.en && (wr.addr == CSR_MCYCLE), wr.en && (wr.addr == CSR_MCYCLEH), wr.data);
        {minstreth_d, minstret_d} = count_step(minstret_q, minstreth_q, retire,
            wr.en && (wr.addr == CSR_MINSTRET), wr.en && (wr.addr == CSR_MINSTRETH), wr.data);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q    <= '0;
            mcycleh_q   <= '0;
            minstret_q  <= '0;
            minstreth_q <= '0;
            mtime_q     <= '0;
        end else begin
            mcycle_q    <= mcycle_d;
            mcycleh_q   <= mcycleh_d;
            minstret_q  <= minstret_d;
            minstreth_q <= minstreth_d;
            // Free running, not writable by software
            mtime_q     <= mtime_q + 1'b1;
        end
    end

    // Shadows read the same registers as the machine counters
    always_comb begin
        view_cnt           = '0;
        view_cnt.cycle     = mcycle_q;
        view_cnt.cycleh    = mcycleh_q;
        view_cnt.instret   = minstret_q;
        view_cnt.instreth  = minstreth_q;
        view_cnt.mcycle    = mcycle_q;
        view_cnt.mcycleh   = mcycleh_q;
        view_cnt.minstret  = minstret_q;
        view_cnt.minstreth = minstreth_q;
        view_cnt.mtime     = mtime_q;
    end

endmodule

`default_nettype wire

// ==== csr_machine_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_machine_regs (
    input  wire                          clk,
    input  wire                          rst,
    input  var csr_if_pkg::csr_trap_t    trap,
    input  wire                          mret,
    input  var csr_if_pkg::csr_wr_t      wr,
    input  wire [`CSR_XLEN-1:0]          mtime,
    output csr_if_pkg::csr_view_t        view_mach,
    output csr_if_pkg::csr_pc_update_t   pc_update
);
    import csr_arch_pkg::*;

    logic [`CSR_XLEN-1:0] mstatus_q;
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] mtval_q;
    logic [`CSR_XLEN-1:0] mip_q;
    logic [`CSR_XLEN-1:0] mtimecmp_q;
    logic                 timer_hit;

    // A zero compare value disarms the timer
    assign timer_hit = (mtime == mtimecmp_q) && (mtime != '0) && (mtimecmp_q != '0);

    // ==========================================================
    // Register update
    // ==========================================================
    // Later assignments take priority: timer, then trap, then software
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= `CSR_MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mip_q      <= '0;
            mtimecmp_q <= '0;
        end else begin
            if (timer_hit) begin
                mip_q[`CSR_MTIP_BIT] <= 1'b1;
            end
            if (trap.valid) begin
                mcause_q <= cause_value(trap.cause);
                mepc_q   <= trap.pc;
                // Interrupts carry no faulting value
                if (trap.cause != TRAP_TIMER) begin
                    mtval_q <= trap.tval;
                end
            end
            if (wr.en) begin
                unique case (wr.addr)
                    CSR_MSTATUS:  mstatus_q  <= wr.data;
                    CSR_MIE:      mie_q      <= wr.data;
                    CSR_MTVEC:    mtvec_q    <= wr.data;
                    CSR_MSCRATCH: mscratch_q <= wr.data;
                    CSR_MEPC:     mepc_q     <= wr.data;
                    CSR_MCAUSE:   mcause_q   <= wr.data;
                    CSR_MTVAL:    mtval_q    <= wr.data;
                    CSR_MIP:      mip_q      <= wr.data;
                    CSR_MTIMECMP: mtimecmp_q <= wr.data;
                    default:      ;
                endcase
            end
        end
    end

    // Same-cycle redirects towards fetch
    assign pc_update.jump_en       = trap.valid;
    assign pc_update.jump_target   = mtvec_q;
    assign pc_update.return_en     = mret;
    assign pc_update.return_target = mepc_q;

    always_comb begin
        view_mach          = '0;
        view_mach.mstatus  = mstatus_q;
        view_mach.mie      = mie_q;
        view_mach.mtvec    = mtvec_q;
        view_mach.mscratch = mscratch_q;
        view_mach.mepc     = mepc_q;
        view_mach.mcause   = mcause_q;
        view_mach.mtval    = mtval_q;
        view_mach.mip      = mip_q;
        view_mach.mtimecmp = mtimecmp_q;
    end

    // Core must only raise the trap kinds this file encodes
    trap_cause_a: assert property (@(posedge clk) disable iff (rst)
        trap.valid |-> trap.cause inside {TRAP_ILLEGAL_INSTR, TRAP_BREAKPOINT,
                                          TRAP_MISALIGNED, TRAP_ILLEGAL_CSR,
                                          TRAP_TIMER});

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                          clk,
    input  wire                          rst,
    input  var csr_if_pkg::csr_req_t     req,
    input  wire                          req_valid,
    output logic                         req_ready,
    output csr_if_pkg::csr_rsp_t         rsp,
    output logic                         rsp_valid,
    input  wire                          rsp_ready,
    input  wire                          retire,
    input  var csr_if_pkg::csr_trap_t    trap,
    input  wire                          mret,
    output csr_if_pkg::csr_pc_update_t   pc_update
);
    import csr_if_pkg::*;

    csr_wr_t        wr;
    csr_view_t      view_cnt;
    csr_view_t      view_mach;
    wire csr_view_t view;

    csr_access_unit u_access (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .wr        (wr),
        .view      (view)
    );

    csr_counters u_counters (
        .clk      (clk),
        .rst      (rst),
        .retire   (retire),
        .wr       (wr),
        .view_cnt (view_cnt)
    );

    csr_machine_regs u_machine (
        .clk       (clk),
        .rst       (rst),
        .trap      (trap),
        .mret      (mret),
        .wr        (wr),
        .mtime     (view_cnt.mtime),
        .view_mach (view_mach),
        .pc_update (pc_update)
    );

    // ==========================================================
    // Merge of the two partial views
    // ==========================================================
    assign view.cycle     = view_cnt.cycle;
    assign view.cycleh    = view_cnt.cycleh;
    assign view.instret   = view_cnt.instret;
    assign view.instreth  = view_cnt.instreth;
    assign view.mcycle    = view_cnt.mcycle;
    assign view.mcycleh   = view_cnt.mcycleh;
    assign view.minstret  = view_cnt.minstret;
    assign view.minstreth = view_cnt.minstreth;
    assign view.mtime     = view_cnt.mtime;
    assign view.mstatus   = view_mach.mstatus;
    assign view.mie       = view_mach.mie;
    assign view.mtvec     = view_mach.mtvec;
    assign view.mscratch  = view_mach.mscratch;
    assign view.mepc      = view_mach.mepc;
    assign view.mcause    = view_mach.mcause;
    assign view.mtval     = view_mach.mtval;
    assign view.mip       = view_mach.mip;
    assign view.mtimecmp  = view_mach.mtimecmp;

endmodule

`default_nettype wire

// ==== tb_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module tb_csr_file;
    import csr_arch_pkg::*;
    import csr_if_pkg::*;

    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] SEED       = 32'h54ca66b3;
    localparam int          N_RAND     = 40;
    localparam int          N_STRESS   = 60;
    localparam int          K_IDLE     = 13;
    localparam int          J_IDLE     = 9;
    localparam int          TIMER_WAIT = 48;
    localparam int          N_REQ      = 2*N_RAND + 7 + 5*5 + 9 + 3 + N_STRESS;
    localparam int          IDLE_CYC   = K_IDLE + J_IDLE + TIMER_WAIT + 10;
    // Requests may stall under random back-pressure
    localparam int          WATCHDOG_CYCLES = 4 * (3*N_REQ + IDLE_CYC);

    logic           clk;
    logic           rst;
    csr_req_t       req;
    logic           req_valid;
    logic           req_ready;
    csr_rsp_t       rsp;
    logic           rsp_valid;
    logic           rsp_ready = 1'b1;
    logic           retire    = 1'b0;
    csr_trap_t      trap;
    logic           mret;
    csr_pc_update_t pc_update;

    // Model state and bookkeeping
    csr_view_t      mdl;
    logic [63:0]    m_cyc;
    logic [63:0]    m_ins;
    csr_rsp_t       exp_q[$];
    string          name_q[$];
    string          test_name;
    int             n_acc     = 0;
    int             n_rsp     = 0;
    int             errors    = 0;
    logic [31:0]    rnd       = SEED;
    logic [31:0]    gap_rnd   = ~SEED;
    logic           gaps_en   = 1'b0;
    logic           retire_en = 1'b0;

    csr_file UUT (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .retire    (retire),
        .trap      (trap),
        .mret      (mret),
        .pc_update (pc_update)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mcause values of the supported trap kinds
    function automatic logic [31:0] expected_cause(input trap_cause_e kind);
        case (kind)
            TRAP_ILLEGAL_INSTR: return 32'd2;
            TRAP_BREAKPOINT:    return 32'd3;
            TRAP_MISALIGNED:    return 32'd4;
            TRAP_ILLEGAL_CSR:   return 32'd11;
            TRAP_TIMER:         return 32'h8000_0007;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] written_value(input csr_op_e op_sel,
                                                  input logic [31:0] old_v,
                                                  input logic [31:0] data);
        case (op_sel)
            CSR_OP_RW: return data;
            CSR_OP_RS: return old_v | data;
            default:   return old_v & ~data;
        endcase
    endfunction

    // Expected response of an access from the model before the edge
    function automatic csr_rsp_t expect_rsp(input csr_req_t r);
        csr_rsp_t    e;
        logic        known;
        logic        ro;
        logic [31:0] v;
        known = 1'b1;
        case (r.addr)
            CSR_CYCLE, CSR_MCYCLE:       v = m_cyc[31:0];
            CSR_CYCLEH, CSR_MCYCLEH:     v = m_cyc[63:32];
            CSR_INSTRET, CSR_MINSTRET:   v = m_ins[31:0];
            CSR_INSTRETH, CSR_MINSTRETH: v = m_ins[63:32];
            CSR_MTIME:                   v = mdl.mtime;
            CSR_MSTATUS:                 v = mdl.mstatus;
            CSR_MIE:                     v = mdl.mie;
            CSR_MTVEC:                   v = mdl.mtvec;
            CSR_MSCRATCH:                v = mdl.mscratch;
            CSR_MEPC:                    v = mdl.mepc;
            CSR_MCAUSE:                  v = mdl.mcause;
            CSR_MTVAL:                   v = mdl.mtval;
            CSR_MIP:                     v = mdl.mip;
            CSR_MTIMECMP:                v = mdl.mtimecmp;
            default: begin
                v     = 32'd0;
                known = 1'b0;
            end
        endcase
        ro = r.addr inside {CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH, CSR_MTIME};
        e.illegal = !known || (r.we && ro);
        e.rdata   = e.illegal ? 32'd0 : v;
        return e;
    endfunction

    function automatic logic [11:0] rw_target(input logic [31:0] r);
        case (r[18:16])
            3'd1:    return CSR_MIE;
            3'd2:    return CSR_MSTATUS;
            3'd3:    return CSR_MTVEC;
            3'd4:    return CSR_MTIMECMP;
            default: return CSR_MSCRATCH;
        endcase
    endfunction

    function automatic csr_op_e pick_op(input logic [31:0] r);
        return (r[13:12] == 2'b00) ? CSR_OP_RW : csr_op_e'(r[13:12]);
    endfunction

    task automatic report_fail(input string what);
        errors++;
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    // Hold one request until the DUT takes it
    // Called on a rising edge
    task automatic send(input csr_op_e op_sel, input logic do_write,
                        input logic [11:0] csr_addr, input logic [31:0] data);
        req       <= '{op: op_sel, we: do_write, addr: csr_addr, wdata: data};
        req_valid <= 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] csr_addr);
        send(CSR_OP_RS, 1'b0, csr_addr, 32'd0);
    endtask

    task automatic raise_trap(input trap_cause_e kind, input logic [31:0] epc,
                              input logic [31:0] bad_val);
        trap <= '{valid: 1'b1, cause: kind, pc: epc, tval: bad_val};
        @(posedge clk);
        trap <= '0;
    endtask

    task automatic pulse_mret();
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
    endtask

    // Back-pressure gaps and retire pulses
    always @(posedge clk) begin
        gap_rnd   <= lcg(gap_rnd);
        rsp_ready <= !gaps_en || (gap_rnd[29:28] != 2'b00);
        retire    <= retire_en && gap_rnd[17];
    end

    // ==========================================================
    // Reference model and same-cycle redirect checks
    // ==========================================================
    always @(posedge clk) begin : model_update
        csr_view_t   nxt;
        logic [63:0] cyc_nxt;
        logic [63:0] ins_nxt;
        logic [31:0] wv;
        csr_rsp_t    e;
        if (rst) begin
            nxt       = '0;
            nxt.mtvec = `CSR_MTVEC_RESET;
            mdl   <= nxt;
            m_cyc <= 64'd0;
            m_ins <= 64'd0;
        end else begin
            nxt       = mdl;
            cyc_nxt   = m_cyc + 64'd1;
            ins_nxt   = m_ins + {63'd0, retire};
            nxt.mtime = mdl.mtime + 32'd1;
            if (mdl.mtime == mdl.mtimecmp && mdl.mtime != 32'd0 && mdl.mtimecmp != 32'd0) begin
                nxt.mip[`CSR_MTIP_BIT] = 1'b1;
            end
            assert (pc_update.jump_en == trap.valid)
                else report_fail("jump request does not follow the trap input");
            if (trap.valid) begin
                assert (pc_update.jump_target == mdl.mtvec)
                    else report_fail($sformatf("mismatch test %s: expected %h, actual %h",
                                     "trap jump", mdl.mtvec, pc_update.jump_target));
                nxt.mcause = expected_cause(trap.cause);
                nxt.mepc   = trap.pc;
                // Interrupts leave mtval alone
                if (trap.cause != TRAP_TIMER) begin
                    nxt.mtval = trap.tval;
                end
            end
            assert (pc_update.return_en == mret)
                else report_fail("return request does not follow the mret input");
            if (mret) begin
                assert (pc_update.return_target == mdl.mepc)
                    else report_fail($sformatf("mismatch test %s: expected %h, actual %h",
                                     "mret", mdl.mepc, pc_update.return_target));
            end
            if (req_valid && req_ready) begin
                e = expect_rsp(req);
                exp_q.push_back(e);
                name_q.push_back(test_name);
                n_acc++;
                if (req.we && !e.illegal) begin
                    wv = written_value(req.op, e.rdata, req.wdata);
                    // Software write wins over increment and trap
                    case (req.addr)
                        CSR_MCYCLE:    cyc_nxt[31:0]  = wv;
                        CSR_MCYCLEH:   cyc_nxt[63:32] = wv;
                        CSR_MINSTRET:  ins_nxt[31:0]  = wv;
                        CSR_MINSTRETH: ins_nxt[63:32] = wv;
                        CSR_MSTATUS:   nxt.mstatus    = wv;
                        CSR_MIE:       nxt.mie        = wv;
                        CSR_MTVEC:     nxt.mtvec      = wv;
                        CSR_MSCRATCH:  nxt.mscratch   = wv;
                        CSR_MEPC:      nxt.mepc       = wv;
                        CSR_MCAUSE:    nxt.mcause     = wv;
                        CSR_MTVAL:     nxt.mtval      = wv;
                        CSR_MIP:       nxt.mip        = wv;
                        CSR_MTIMECMP:  nxt.mtimecmp   = wv;
                        default:       ;
                    endcase
                end
            end
            mdl   <= nxt;
            m_cyc <= cyc_nxt;
            m_ins <= ins_nxt;
        end
    end

    // Compare each consumed response in order
    always @(posedge clk) begin : compare
        csr_rsp_t e;
        string    name;
        if (!rst) begin
            assert (req_ready == (!rsp_valid || rsp_ready))
                else report_fail("request ready does not match the response slot state");
        end
        if (!rst && rsp_valid && rsp_ready) begin
            assert (exp_q.size() > 0)
                else report_fail("response arrived with no request outstanding");
            e    = exp_q.pop_front();
            name = name_q.pop_front();
            n_rsp++;
            assert (rsp === e)
                else report_fail($sformatf("mismatch test %s: expected %h/%b, actual %h/%b",
                                 name, e.rdata, e.illegal, rsp.rdata, rsp.illegal));
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_fail($sformatf("timeout, run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin : stimulus
        logic [31:0] target;
        rst       <= 1'b1;
        req       <= '0;
        req_valid <= 1'b0;
        trap      <= '0;
        mret      <= 1'b0;
        test_name <= "reset";
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_name <= "rw_rs_rc";
        gaps_en   <= 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            rnd    = lcg(rnd);
            target = lcg(rnd);
            send(pick_op(rnd), 1'b1, rw_target(rnd), target);
            read_csr(rw_target(rnd));
        end

        test_name <= "illegal";
        gaps_en   <= 1'b0;
        send(CSR_OP_RW, 1'b1, 12'h123, 32'hdead_beef);
        send(CSR_OP_RS, 1'b0, 12'h7ff, 32'h0);
        send(CSR_OP_RW, 1'b1, CSR_CYCLE, 32'h1234_5678);
        send(CSR_OP_RS, 1'b1, CSR_INSTRET, 32'hffff_ffff);
        send(CSR_OP_RC, 1'b1, CSR_MTIME, 32'hffff_ffff);
        read_csr(CSR_MTIME);
        read_csr(CSR_CYCLE);

        test_name <= "trap";
        for (int c = 0; c < 5; c++) begin
            rnd    = lcg(rnd);
            target = lcg(rnd);
            raise_trap(trap_cause_e'(c), {rnd[31:2], 2'b00}, target);
            read_csr(CSR_MCAUSE);
            read_csr(CSR_MEPC);
            read_csr(CSR_MTVAL);
            pulse_mret();
        end

        test_name <= "counters";
        retire_en <= 1'b1;
        read_csr(CSR_MCYCLE);
        repeat (K_IDLE) @(posedge clk);
        read_csr(CSR_MCYCLE);
        read_csr(CSR_MINSTRET);
        read_csr(CSR_INSTRETH);
        // Low half close to wrap so the carry reaches mcycleh
        send(CSR_OP_RW, 1'b1, CSR_MCYCLE, 32'hffff_fff8);
        repeat (J_IDLE) @(posedge clk);
        read_csr(CSR_MCYCLE);
        read_csr(CSR_MCYCLEH);
        send(CSR_OP_RW, 1'b1, CSR_MINSTRETH, 32'h0000_0005);
        read_csr(CSR_INSTRETH);
        retire_en <= 1'b0;

        test_name <= "timer";
        target = mdl.mtime + 32'd24;
        send(CSR_OP_RW, 1'b1, CSR_MTIMECMP, target);
        // Pending flag still clear before the compare point
        read_csr(CSR_MIP);
        repeat (TIMER_WAIT) @(posedge clk);
        assert (mdl.mip[`CSR_MTIP_BIT])
            else report_fail("mtime never reached the compare value");
        read_csr(CSR_MIP);

        test_name <= "backpressure";
        gaps_en   <= 1'b1;
        for (int i = 0; i < N_STRESS; i++) begin
            rnd    = lcg(rnd);
            target = lcg(rnd);
            if (rnd[5]) begin
                send(pick_op(rnd), 1'b1, rw_target(rnd), target);
            end else begin
                read_csr(rnd[6] ? CSR_MCYCLE : rw_target(rnd));
            end
        end

        gaps_en <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (n_acc == n_rsp)
            else report_fail($sformatf("%0d requests accepted but %0d responses seen",
                             n_acc, n_rsp));
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
csr_arch_pkg.sv
csr_if_pkg.sv
csr_access_unit.sv
csr_counters.sv
csr_machine_regs.sv
csr_file.sv
tb_csr_file.sv

// ==== Makefile ====
# Verilator build and run for the CSR file testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_file
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
